// File: verilog/vertex_consts.svh
`ifndef VERTEX_CONSTS_SVH
`define VERTEX_CONSTS_SVH

// Width of one vertex field in a line
`define VERTEX_BITS 32

// Vertices carried by one cache line
`define LINE_VERTICES 4
`define LINE_BITS 128

// Address step from one chunk to the next
`define LINE_BYTES 16

`define ADDR_BITS 32

// Vertex counts and vertex ids
`define COUNT_BITS 16

// Job FIFO entries
`define JOB_FIFO_DEPTH 16

`endif

// File: verilog/vertex_pkg.sv
package vertex_pkg;

	`include "vertex_consts.svh"

	// Which vertex array a command or a returned line belongs to
	typedef enum logic [1:0] {
		IN_DEGREE  = 2'd0,
		OUT_DEGREE = 2'd1,
		EDGES_IDX  = 2'd2
	} array_sel_t;

	// Read issuer FSM
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		CHECK      = 3'd1,
		SEND_IN    = 3'd2,
		SEND_OUT   = 3'd3,
		SEND_EDGES = 3'd4,
		WAIT_LINE  = 3'd5
	} issuer_state_t;

	// One unpacked vertex job
	typedef struct packed {
		logic [`COUNT_BITS-1:0]  id;
		logic [`VERTEX_BITS-1:0] in_degree;
		logic [`VERTEX_BITS-1:0] out_degree;
		logic [`VERTEX_BITS-1:0] edges_idx;
	} vertex_job_t;

endpackage

// File: verilog/vertex_line_if.sv
`timescale 1ns/1ps

`include "vertex_consts.svh"

// One buffered chunk, line store to job queue
interface vertex_line_if;

	logic [`LINE_BITS-1:0]  in_line;
	logic [`LINE_BITS-1:0]  out_line;
	logic [`LINE_BITS-1:0]  edges_line;
	logic [`COUNT_BITS-1:0] count;
	// All three lines of the chunk are present
	logic                   full;
	// Single pulse once the queue has unpacked the chunk
	logic                   chunk_release;

	modport store (
		output in_line, out_line, edges_line, count, full,
		input  chunk_release
	);

	modport queue (
		input  in_line, out_line, edges_line, count, full,
		output chunk_release
	);

endinterface

// File: verilog/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       push,
	input  logic [WIDTH-1:0]           data_in,
	input  logic                       pop,
	output logic [WIDTH-1:0]           data_out,
	output logic                       out_valid,
	output logic                       empty,
	output logic [$clog2(DEPTH+1)-1:0] fill
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic                do_push;
	logic                do_pop;

	// Circular wrap, DEPTH need not be a power of two
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty   = (fill == '0);
	assign do_pop  = pop && !empty;
	assign do_push = push && ((fill < DEPTH) || do_pop);

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
		if (do_pop)
			data_out <= mem[rd_ptr];
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			fill      <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= do_pop;
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

// File: verilog/vertex_read_issuer.sv
`timescale 1ns/1ps

`include "vertex_consts.svh"

module vertex_read_issuer (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   start,
	input  logic [`COUNT_BITS-1:0] num_vertices,
	input  logic [`ADDR_BITS-1:0]  base_in,
	input  logic [`ADDR_BITS-1:0]  base_out,
	input  logic [`ADDR_BITS-1:0]  base_edges,
	input  logic                   space_ok,
	input  logic                   line_done,
	output logic                   cmd_valid,
	output logic [`ADDR_BITS-1:0]  cmd_addr,
	output vertex_pkg::array_sel_t cmd_array,
	output logic [`COUNT_BITS-1:0] cmd_count,
	output logic                   chunk_load,
	output logic [`COUNT_BITS-1:0] chunk_count,
	output logic                   busy
);

	import vertex_pkg::*;

	issuer_state_t state;

	logic [`COUNT_BITS-1:0] remaining;
	logic [`ADDR_BITS-1:0]  offset;
	logic [`COUNT_BITS-1:0] chunk_size;

	logic [`ADDR_BITS-1:0] base_in_q;
	logic [`ADDR_BITS-1:0] base_out_q;
	logic [`ADDR_BITS-1:0] base_edges_q;

	// Last chunk may be short
	assign chunk_size = (remaining > `COUNT_BITS'(`LINE_VERTICES)) ?
		`COUNT_BITS'(`LINE_VERTICES) : remaining;

	assign busy = (state != IDLE);

	////////////////////////////////////////////////////////////////////////////
	// Command outputs in the SEND states
	////////////////////////////////////////////////////////////////////////////

	assign cmd_valid   = (state == SEND_IN) || (state == SEND_OUT) || (state == SEND_EDGES);
	assign cmd_count   = chunk_size;
	assign chunk_load  = (state == SEND_IN);
	assign chunk_count = chunk_size;

	always_comb begin
		case (state)
			SEND_OUT: begin
				cmd_array = OUT_DEGREE;
				cmd_addr  = base_out_q + offset;
			end
			SEND_EDGES: begin
				cmd_array = EDGES_IDX;
				cmd_addr  = base_edges_q + offset;
			end
			default: begin
				cmd_array = IN_DEGREE;
				cmd_addr  = base_in_q + offset;
			end
		endcase
	end

	// Bases latched on an accepted start
	always_ff @(posedge clock) begin
		if (state == IDLE && start) begin
			base_in_q    <= base_in;
			base_out_q   <= base_out;
			base_edges_q <= base_edges;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Chunking FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= IDLE;
			remaining <= '0;
			offset    <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						remaining <= num_vertices;
						offset    <= '0;
						state     <= CHECK;
					end
				end
				CHECK: begin
					// Hold here until the job FIFO can take a whole line
					if (remaining == '0)
						state <= IDLE;
					else if (space_ok)
						state <= SEND_IN;
				end
				SEND_IN: state <= SEND_OUT;
				SEND_OUT: state <= SEND_EDGES;
				SEND_EDGES: state <= WAIT_LINE;
				WAIT_LINE: begin
					if (line_done) begin
						remaining <= remaining - chunk_size;
						offset    <= offset + `ADDR_BITS'(`LINE_BYTES);
						state     <= CHECK;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: verilog/vertex_line_store.sv
`timescale 1ns/1ps

`include "vertex_consts.svh"

module vertex_line_store (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   data_valid,
	input  vertex_pkg::array_sel_t data_array,
	input  logic [`LINE_BITS-1:0]  data_line,
	input  logic                   chunk_load,
	input  logic [`COUNT_BITS-1:0] chunk_count,
	output logic                   line_done,
	vertex_line_if.store           line
);

	import vertex_pkg::*;

	logic [`LINE_BITS-1:0] in_q;
	logic [`LINE_BITS-1:0] out_q;
	logic [`LINE_BITS-1:0] edges_q;

	logic                   in_seen;
	logic                   out_seen;
	logic                   edges_seen;
	logic [`COUNT_BITS-1:0] count_q;

	assign line.in_line    = in_q;
	assign line.out_line   = out_q;
	assign line.edges_line = edges_q;
	assign line.count      = count_q;
	assign line.full       = in_seen && out_seen && edges_seen;

	// Queue finished the chunk, the issuer may move on
	assign line_done = line.chunk_release;

	// Line payload, a repeated array simply overwrites
	always_ff @(posedge clock) begin
		if (data_valid) begin
			case (data_array)
				IN_DEGREE:  in_q    <= data_line;
				OUT_DEGREE: out_q   <= data_line;
				EDGES_IDX:  edges_q <= data_line;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			in_seen    <= 1'b0;
			out_seen   <= 1'b0;
			edges_seen <= 1'b0;
			count_q    <= '0;
		end else begin
			if (chunk_load)
				count_q <= chunk_count;
			if (line.chunk_release) begin
				in_seen    <= 1'b0;
				out_seen   <= 1'b0;
				edges_seen <= 1'b0;
			end
			// Arrival wins over a clear in the same cycle
			if (data_valid) begin
				case (data_array)
					IN_DEGREE:  in_seen    <= 1'b1;
					OUT_DEGREE: out_seen   <= 1'b1;
					EDGES_IDX:  edges_seen <= 1'b1;
					default: ;
				endcase
			end
		end
	end

endmodule

// File: verilog/vertex_job_queue.sv
`timescale 1ns/1ps

`include "vertex_consts.svh"

module vertex_job_queue (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    start,
	input  logic                    vertex_request,
	vertex_line_if.queue            line,
	output logic                    space_ok,
	output logic                    vertex_valid,
	output logic [`COUNT_BITS-1:0]  vertex_id,
	output logic [`VERTEX_BITS-1:0] vertex_in_degree,
	output logic [`VERTEX_BITS-1:0] vertex_out_degree,
	output logic [`VERTEX_BITS-1:0] vertex_edges_idx,
	output logic [`VERTEX_BITS-1:0] jobs_filtered,
	output logic [`VERTEX_BITS-1:0] jobs_issued,
	output logic [`VERTEX_BITS-1:0] edges_issued
);

	import vertex_pkg::*;

	localparam int FILL_BITS = $clog2(`JOB_FIFO_DEPTH + 1);

	logic                   unpacking;
	logic [`COUNT_BITS-1:0] unpack_idx;
	logic [`COUNT_BITS-1:0] next_id;
	logic                   last_vertex;
	logic                   push_job;
	logic                   drop_job;

	vertex_job_t            cur_job;
	vertex_job_t            popped_job;
	logic                   fifo_empty;
	logic [FILL_BITS-1:0]   fifo_fill;

	////////////////////////////////////////////////////////////////////////////
	// Unpack one vertex per cycle, lowest first
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		cur_job.id         = next_id;
		cur_job.in_degree  = line.in_line[unpack_idx*`VERTEX_BITS +: `VERTEX_BITS];
		cur_job.out_degree = line.out_line[unpack_idx*`VERTEX_BITS +: `VERTEX_BITS];
		cur_job.edges_idx  = line.edges_line[unpack_idx*`VERTEX_BITS +: `VERTEX_BITS];
	end

	assign last_vertex = unpacking && (unpack_idx == line.count - 1'b1);
	assign line.chunk_release = last_vertex;

	// No outgoing edges, nothing to schedule
	assign push_job = unpacking && (cur_job.out_degree != '0);
	assign drop_job = unpacking && (cur_job.out_degree == '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			unpacking  <= 1'b0;
			unpack_idx <= '0;
			next_id    <= '0;
		end else begin
			if (!unpacking && line.full) begin
				unpacking  <= 1'b1;
				unpack_idx <= '0;
			end else if (unpacking) begin
				if (last_vertex)
					unpacking <= 1'b0;
				else
					unpack_idx <= unpack_idx + 1'b1;
			end
			// Ids run across chunks and restart with each job set
			if (start)
				next_id <= '0;
			else if (unpacking)
				next_id <= next_id + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Job FIFO
	////////////////////////////////////////////////////////////////////////////

	sync_fifo #(
		.WIDTH($bits(vertex_job_t)),
		.DEPTH(`JOB_FIFO_DEPTH)
	) job_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.push     (push_job),
		.data_in  (cur_job),
		.pop      (vertex_request),
		.data_out (popped_job),
		.out_valid(vertex_valid),
		.empty    (fifo_empty),
		.fill     (fifo_fill)
	);

	// Room for a whole line of jobs
	assign space_ok = fifo_empty || (fifo_fill <= (`JOB_FIFO_DEPTH - `LINE_VERTICES));

	assign vertex_id         = popped_job.id;
	assign vertex_in_degree  = popped_job.in_degree;
	assign vertex_out_degree = popped_job.out_degree;
	assign vertex_edges_idx  = popped_job.edges_idx;

	// Running totals, kept across starts
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			jobs_filtered <= '0;
			jobs_issued   <= '0;
			edges_issued  <= '0;
		end else begin
			if (drop_job)
				jobs_filtered <= jobs_filtered + 1'b1;
			if (vertex_valid) begin
				jobs_issued  <= jobs_issued + 1'b1;
				edges_issued <= edges_issued + vertex_out_degree;
			end
		end
	end

endmodule

// File: verilog/vertex_job_control.sv
`timescale 1ns/1ps

`include "vertex_consts.svh"

module vertex_job_control (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    start,
	input  logic [`COUNT_BITS-1:0]  num_vertices,
	input  logic [`ADDR_BITS-1:0]   base_in,
	input  logic [`ADDR_BITS-1:0]   base_out,
	input  logic [`ADDR_BITS-1:0]   base_edges,
	output logic                    cmd_valid,
	output logic [`ADDR_BITS-1:0]   cmd_addr,
	output vertex_pkg::array_sel_t  cmd_array,
	output logic [`COUNT_BITS-1:0]  cmd_count,
	input  logic                    data_valid,
	input  vertex_pkg::array_sel_t  data_array,
	input  logic [`LINE_BITS-1:0]   data_line,
	input  logic                    vertex_request,
	output logic                    vertex_valid,
	output logic [`COUNT_BITS-1:0]  vertex_id,
	output logic [`VERTEX_BITS-1:0] vertex_in_degree,
	output logic [`VERTEX_BITS-1:0] vertex_out_degree,
	output logic [`VERTEX_BITS-1:0] vertex_edges_idx,
	output logic [`VERTEX_BITS-1:0] jobs_filtered,
	output logic [`VERTEX_BITS-1:0] jobs_issued,
	output logic [`VERTEX_BITS-1:0] edges_issued,
	output logic                    busy
);

	logic                   chunk_load;
	logic [`COUNT_BITS-1:0] chunk_count;
	logic                   line_done;
	logic                   space_ok;

	vertex_line_if line_bus ();

	vertex_read_issuer issuer (
		.clock       (clock),
		.rstn        (rstn),
		.start       (start),
		.num_vertices(num_vertices),
		.base_in     (base_in),
		.base_out    (base_out),
		.base_edges  (base_edges),
		.space_ok    (space_ok),
		.line_done   (line_done),
		.cmd_valid   (cmd_valid),
		.cmd_addr    (cmd_addr),
		.cmd_array   (cmd_array),
		.cmd_count   (cmd_count),
		.chunk_load  (chunk_load),
		.chunk_count (chunk_count),
		.busy        (busy)
	);

	vertex_line_store line_store (
		.clock      (clock),
		.rstn       (rstn),
		.data_valid (data_valid),
		.data_array (data_array),
		.data_line  (data_line),
		.chunk_load (chunk_load),
		.chunk_count(chunk_count),
		.line_done  (line_done),
		.line       (line_bus.store)
	);

	// Id restart only for a start the issuer takes, so only while idle
	vertex_job_queue job_queue (
		.clock            (clock),
		.rstn             (rstn),
		.start            (start && !busy),
		.vertex_request   (vertex_request),
		.line             (line_bus.queue),
		.space_ok         (space_ok),
		.vertex_valid     (vertex_valid),
		.vertex_id        (vertex_id),
		.vertex_in_degree (vertex_in_degree),
		.vertex_out_degree(vertex_out_degree),
		.vertex_edges_idx (vertex_edges_idx),
		.jobs_filtered    (jobs_filtered),
		.jobs_issued      (jobs_issued),
		.edges_issued     (edges_issued)
	);

endmodule

// File: testbench/vertex_job_control_assertions.sv
`timescale 1ns/1ps

`include "vertex_consts.svh"

module vertex_job_control_assertions (
	input logic                    clock,
	input logic                    rstn,
	input logic                    cmd_valid,
	input vertex_pkg::array_sel_t  cmd_array,
	input logic                    vertex_request,
	input logic                    vertex_valid,
	input logic [`VERTEX_BITS-1:0] vertex_out_degree
);

	import vertex_pkg::*;

	// Number of failed assertions so far
	int failures = 0;

	// Every command group opens with the in-degree line
	a_group_start: assert property (@(posedge clock) disable iff (!rstn)
		$rose(cmd_valid) |-> (cmd_array == IN_DEGREE))
	else begin
		failures++;
		$error("command group did not start with IN_DEGREE");
	end

	// Out-degree and edge index follow on back-to-back cycles before a gap
	a_group_order: assert property (@(posedge clock) disable iff (!rstn)
		(cmd_valid && cmd_array == IN_DEGREE) |=>
		(cmd_valid && cmd_array == OUT_DEGREE) ##1
		(cmd_valid && cmd_array == EDGES_IDX) ##1 !cmd_valid)
	else begin
		failures++;
		$error("command group out of order");
	end

	// Zero out-degree vertices are filtered before the FIFO
	a_no_zero_job: assert property (@(posedge clock) disable iff (!rstn)
		vertex_valid |-> (vertex_out_degree != '0))
	else begin
		failures++;
		$error("job handed out with zero out-degree");
	end

	a_valid_after_request: assert property (@(posedge clock) disable iff (!rstn)
		vertex_valid |-> $past(vertex_request))
	else begin
		failures++;
		$error("vertex_valid without a request in the cycle before");
	end

endmodule

// File: testbench/vertex_job_control_tb.sv
`timescale 1ns/1ps

`include "vertex_consts.svh"

module vertex_job_control_tb;

	import vertex_pkg::*;

	// Longest test is the 500-cycle stall plus a few hundred cycles
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int MAX_VERTICES   = 64;
	localparam int LOG_SIZE       = 256;

	logic                    clock;
	logic                    rstn;
	logic                    start;
	logic [`COUNT_BITS-1:0]  num_vertices;
	logic [`ADDR_BITS-1:0]   base_in;
	logic [`ADDR_BITS-1:0]   base_out;
	logic [`ADDR_BITS-1:0]   base_edges;
	logic                    cmd_valid;
	logic [`ADDR_BITS-1:0]   cmd_addr;
	array_sel_t              cmd_array;
	logic [`COUNT_BITS-1:0]  cmd_count;
	logic                    data_valid;
	array_sel_t              data_array;
	logic [`LINE_BITS-1:0]   data_line;
	logic                    vertex_request;
	logic                    vertex_valid;
	logic [`COUNT_BITS-1:0]  vertex_id;
	logic [`VERTEX_BITS-1:0] vertex_in_degree;
	logic [`VERTEX_BITS-1:0] vertex_out_degree;
	logic [`VERTEX_BITS-1:0] vertex_edges_idx;
	logic [`VERTEX_BITS-1:0] jobs_filtered;
	logic [`VERTEX_BITS-1:0] jobs_issued;
	logic [`VERTEX_BITS-1:0] edges_issued;
	logic                    busy;

	// Reference vertex arrays of the current job set
	logic [`VERTEX_BITS-1:0] ref_in [MAX_VERTICES];
	logic [`VERTEX_BITS-1:0] ref_out [MAX_VERTICES];
	logic [`VERTEX_BITS-1:0] ref_edges [MAX_VERTICES];
	int                      cur_num;
	logic [`ADDR_BITS-1:0]   cur_base [3];

	// Everything seen on the command and job ports
	logic [`ADDR_BITS-1:0]   log_addr [LOG_SIZE];
	array_sel_t              log_array [LOG_SIZE];
	logic [`COUNT_BITS-1:0]  log_count [LOG_SIZE];
	logic [`COUNT_BITS-1:0]  got_id [LOG_SIZE];
	logic [`VERTEX_BITS-1:0] got_in [LOG_SIZE];
	logic [`VERTEX_BITS-1:0] got_out [LOG_SIZE];
	logic [`VERTEX_BITS-1:0] got_edges [LOG_SIZE];
	int                      cmd_total = 0;
	int                      job_total = 0;
	int                      cmd_first;
	int                      job_first;

	logic [31:0]             rng_state;
	logic                    pop_enable;
	logic                    mem_shuffle;
	int                      errors;
	int                      checks;
	int                      assert_failures;
	int                      exp_kept;
	logic [31:0]             exp_filtered;
	logic [31:0]             exp_issued;
	logic [31:0]             exp_edges;

	vertex_job_control vertex_job_control_inst (.*);

	bind vertex_job_control vertex_job_control_assertions assertions_inst (
		.clock            (clock),
		.rstn             (rstn),
		.cmd_valid        (cmd_valid),
		.cmd_array        (cmd_array),
		.vertex_request   (vertex_request),
		.vertex_valid     (vertex_valid),
		.vertex_out_degree(vertex_out_degree)
	);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Line for one command from the address and the reference arrays
	function automatic logic [`LINE_BITS-1:0] build_line(input array_sel_t arr,
		input logic [`ADDR_BITS-1:0] addr);
		logic [`LINE_BITS-1:0]   packed_line;
		logic [`VERTEX_BITS-1:0] word;
		int                      first;
		int                      idx;
		first = int'((addr - cur_base[arr]) / `LINE_BYTES) * `LINE_VERTICES;
		for (int k = 0; k < `LINE_VERTICES; k++) begin
			idx = first + k;
			if (idx >= 0 && idx < cur_num) begin
				case (arr)
					OUT_DEGREE: word = ref_out[idx];
					EDGES_IDX:  word = ref_edges[idx];
					default:    word = ref_in[idx];
				endcase
			end else begin
				// Unused lanes past the vertex count
				word = addr ^ 32'(k);
			end
			packed_line[k*`VERTEX_BITS +: `VERTEX_BITS] = word;
		end
		return packed_line;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Monitors, memory model and consumer
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		if (cmd_valid && cmd_total < LOG_SIZE) begin
			log_addr[cmd_total]  = cmd_addr;
			log_array[cmd_total] = cmd_array;
			log_count[cmd_total] = cmd_count;
			cmd_total++;
		end
		if (vertex_valid && job_total < LOG_SIZE) begin
			got_id[job_total]    = vertex_id;
			got_in[job_total]    = vertex_in_degree;
			got_out[job_total]   = vertex_out_degree;
			got_edges[job_total] = vertex_edges_idx;
			job_total++;
		end
	end

	// Answers each group of three commands with three lines
	initial begin : memory_model
		array_sel_t            grp_array [3];
		logic [`ADDR_BITS-1:0] grp_addr [3];
		int                    order [3];
		int                    served;
		int                    pick;
		int                    tmp;
		int                    gap;
		data_valid = 1'b0;
		data_array = IN_DEGREE;
		data_line  = '0;
		served     = 0;
		forever begin
			wait (cmd_total >= served + 3);
			for (int i = 0; i < 3; i++) begin
				grp_array[i] = log_array[served + i];
				grp_addr[i]  = log_addr[served + i];
				order[i]     = i;
			end
			served += 3;
			if (mem_shuffle) begin
				for (int i = 2; i > 0; i--) begin
					pick        = int'(next_random() % (i + 1));
					tmp         = order[i];
					order[i]    = order[pick];
					order[pick] = tmp;
				end
			end
			for (int i = 0; i < 3; i++) begin
				@(posedge clock);
				#1;
				data_valid = 1'b1;
				data_array = grp_array[order[i]];
				data_line  = build_line(grp_array[order[i]], grp_addr[order[i]]);
				@(posedge clock);
				#1;
				data_valid = 1'b0;
				gap = mem_shuffle ? int'(next_random() % 4) : 0;
				repeat (gap) @(posedge clock);
			end
		end
	end

	initial begin : pop_driver
		vertex_request = 1'b0;
		forever begin
			@(posedge clock);
			#1;
			vertex_request = pop_enable;
		end
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Job set helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic fill_vertices(input int n, input bit allow_zero);
		logic [31:0] r;
		for (int v = 0; v < n; v++) begin
			r            = next_random();
			ref_in[v]    = r & 32'hffff;
			r            = next_random();
			ref_out[v]   = (allow_zero && r[1:0] == 2'b00) ? '0 : (r % 50) + 1;
			ref_edges[v] = next_random();
		end
	endtask

	task automatic drive_start(input int n, input logic [31:0] bi, input logic [31:0] bo,
		input logic [31:0] be);
		@(posedge clock);
		#1;
		start        = 1'b1;
		num_vertices = n;
		base_in      = bi;
		base_out     = bo;
		base_edges   = be;
		@(posedge clock);
		#1;
		start = 1'b0;
	endtask

	task automatic start_set(input int n, input logic [31:0] bi, input logic [31:0] bo,
		input logic [31:0] be);
		cur_num     = n;
		cur_base[0] = bi;
		cur_base[1] = bo;
		cur_base[2] = be;
		cmd_first   = cmd_total;
		job_first   = job_total;
		exp_kept    = 0;
		for (int v = 0; v < n; v++) begin
			if (ref_out[v] == '0) begin
				exp_filtered++;
			end else begin
				exp_kept++;
				exp_issued++;
				exp_edges += ref_out[v];
			end
		end
		drive_start(n, bi, bo, be);
	endtask

	task automatic wait_set_done();
		while (busy || (job_total - job_first) < exp_kept)
			@(negedge clock);
		// Counters settle one cycle after the last job
		repeat (3) @(negedge clock);
	endtask

	task automatic check_set();
		int chunks;
		int idx;
		int left;
		int j;
		chunks = (cur_num + `LINE_VERTICES - 1) / `LINE_VERTICES;
		check_value("command count", cmd_total - cmd_first, chunks * 3);
		for (int c = 0; c < chunks && cmd_first + 3 * c + 2 < cmd_total; c++) begin
			left = cur_num - c * `LINE_VERTICES;
			for (int a = 0; a < 3; a++) begin
				idx = cmd_first + 3 * c + a;
				check_value("cmd_array", log_array[idx], a);
				check_value("cmd_addr", log_addr[idx], cur_base[a] + c * `LINE_BYTES);
				check_value("cmd_count", log_count[idx],
					(left > `LINE_VERTICES) ? `LINE_VERTICES : left);
			end
		end
		check_value("job count", job_total - job_first, exp_kept);
		j = job_first;
		for (int v = 0; v < cur_num; v++) begin
			if (ref_out[v] != '0 && j < job_total) begin
				check_value("vertex_id", got_id[j], v);
				check_value("vertex_in_degree", got_in[j], ref_in[v]);
				check_value("vertex_out_degree", got_out[j], ref_out[v]);
				check_value("vertex_edges_idx", got_edges[j], ref_edges[v]);
				j++;
			end
		end
		check_value("jobs_filtered", jobs_filtered, exp_filtered);
		check_value("jobs_issued", jobs_issued, exp_issued);
		check_value("edges_issued", edges_issued, exp_edges);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic check_idle_outputs();
		check_value("cmd_valid", cmd_valid, 0);
		check_value("vertex_valid", vertex_valid, 0);
		check_value("busy", busy, 0);
		check_value("jobs_filtered", jobs_filtered, 0);
		check_value("jobs_issued", jobs_issued, 0);
		check_value("edges_issued", edges_issued, 0);
	endtask

	task automatic test_reset();
		repeat (10) @(posedge clock);
		check_idle_outputs();
		#1;
		rstn = 1'b1;
		repeat (2) @(negedge clock);
		check_idle_outputs();
	endtask

	task automatic test_single_chunk();
		pop_enable  = 1'b1;
		mem_shuffle = 1'b0;
		fill_vertices(3, 1'b0);
		start_set(3, 32'h0000_1000, 32'h0000_2000, 32'h0000_3000);
		wait_set_done();
		check_set();
	endtask

	task automatic test_multi_chunk();
		pop_enable  = 1'b1;
		mem_shuffle = 1'b1;
		fill_vertices(10, 1'b1);
		ref_out[1] = '0;
		ref_out[6] = '0;
		start_set(10, 32'h0001_0040, 32'h0002_0080, 32'h0003_00c0);
		wait_set_done();
		check_set();
	endtask

	task automatic test_back_pressure();
		pop_enable  = 1'b0;
		mem_shuffle = 1'b0;
		fill_vertices(24, 1'b0);
		start_set(24, 32'h0004_0000, 32'h0005_0000, 32'h0006_0000);
		repeat (500) @(negedge clock);
		// Four chunks fill the job FIFO
		check_value("commands while stalled", cmd_total - cmd_first, 12);
		check_value("jobs while stalled", job_total - job_first, 0);
		pop_enable = 1'b1;
		wait_set_done();
		check_set();
	endtask

	task automatic test_restart();
		pop_enable  = 1'b1;
		mem_shuffle = 1'b0;
		fill_vertices(5, 1'b0);
		start_set(5, 32'h0007_0000, 32'h0007_1000, 32'h0007_2000);
		// Issuer is busy so this start is dropped
		drive_start(7, 32'h0009_0000, 32'h0009_1000, 32'h0009_2000);
		wait_set_done();
		check_set();
		fill_vertices(6, 1'b1);
		start_set(6, 32'h000a_0000, 32'h000b_0000, 32'h000c_0000);
		wait_set_done();
		check_set();
	endtask

	initial begin
		rstn         = 1'b0;
		start        = 1'b0;
		num_vertices = '0;
		base_in      = '0;
		base_out     = '0;
		base_edges   = '0;
		rng_state    = 32'h4600;
		pop_enable   = 1'b0;
		mem_shuffle  = 1'b0;
		errors       = 0;
		checks       = 0;
		exp_filtered = '0;
		exp_issued   = '0;
		exp_edges    = '0;
		test_reset();
		test_single_chunk();
		test_multi_chunk();
		test_back_pressure();
		test_restart();
		assert_failures = vertex_job_control_inst.assertions_inst.failures;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, assert_failures);
		if (errors == 0 && assert_failures == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: build.f
+incdir+verilog
verilog/vertex_pkg.sv
verilog/vertex_line_if.sv
verilog/sync_fifo.sv
verilog/vertex_read_issuer.sv
verilog/vertex_line_store.sv
verilog/vertex_job_queue.sv
verilog/vertex_job_control.sv
testbench/vertex_job_control_assertions.sv
testbench/vertex_job_control_tb.sv
